// File: common/memctrl_pkg.sv
`default_nettype none

package memctrl_pkg;

    // Cache geometry
    localparam int unsigned NUM_WAYS   = 4;
    localparam int unsigned NUM_SETS   = 16;
    localparam int unsigned CL_WORDS   = 4;
    localparam int unsigned WORD_WIDTH = 32;
    localparam int unsigned TAG_WIDTH  = 8;

    // Derived widths
    localparam int unsigned SET_WIDTH       = $clog2(NUM_SETS);
    localparam int unsigned WORD_IDX_WIDTH  = $clog2(CL_WORDS);
    localparam int unsigned DATA_ADDR_WIDTH = SET_WIDTH + WORD_IDX_WIDTH;
    localparam int unsigned BE_WIDTH        = WORD_WIDTH / 8;
    localparam int unsigned DATA_DEPTH      = NUM_SETS * CL_WORDS;

    typedef logic [SET_WIDTH-1:0]      set_t;
    typedef logic [TAG_WIDTH-1:0]      tag_t;
    typedef logic [WORD_IDX_WIDTH-1:0] word_idx_t;
    typedef logic [NUM_WAYS-1:0]       way_vec_t;
    typedef logic [WORD_WIDTH-1:0]     data_word_t;
    typedef logic [BE_WIDTH-1:0]       be_t;

    // One directory entry per set and way
    typedef struct packed {
        logic valid;
        tag_t tag;
    } dir_entry_t;

    localparam int unsigned DIR_ENTRY_WIDTH = $bits(dir_entry_t);

    typedef enum logic {
        INIT_CLEAR,
        INIT_DONE
    } init_state_e;

    // Directory access granted in the current cycle
    typedef enum logic [2:0] {
        DIR_IDLE,
        DIR_INIT,
        DIR_MATCH,
        DIR_SEL_VICTIM,
        DIR_REFILL
    } dir_op_e;

endpackage

`default_nettype wire

// File: common/plru_if.sv
`timescale 1ns/1ps
`default_nettype none

interface plru_if;
    import memctrl_pkg::*;

    // MRU update after a lookup
    logic     updt;
    set_t     updt_set;
    way_vec_t updt_way;

    // Replacement side
    logic     repl;
    set_t     repl_set;
    way_vec_t repl_valid;
    way_vec_t victim_way;

    modport ctrl (
        output updt, updt_set, updt_way,
        output repl, repl_set, repl_valid,
        input  victim_way
    );

    modport sel (
        input  updt, updt_set, updt_way,
        input  repl, repl_set, repl_valid,
        output victim_way
    );

endinterface

`default_nettype wire

// File: hw/sram_1rw.sv
`timescale 1ns/1ps
`default_nettype none

module sram_1rw #(
    parameter int unsigned DATA_WIDTH = 32,
    parameter int unsigned DEPTH      = 64,
    localparam int unsigned BEW       = (DATA_WIDTH + 7) / 8,
    localparam int unsigned AW        = $clog2(DEPTH)
) (
    input  wire logic                  clk_i,
    input  wire logic                  cs_i,
    input  wire logic                  we_i,
    input  wire logic [BEW-1:0]        be_i,
    input  wire logic [AW-1:0]         addr_i,
    input  wire logic [DATA_WIDTH-1:0] wdata_i,
    output logic      [DATA_WIDTH-1:0] rdata_o
);

    logic [DATA_WIDTH-1:0] mem_q [DEPTH];

    // Bit i follows byte enable i/8, so the last enable covers any leftover bits
    always_ff @(posedge clk_i) begin
        if (cs_i && we_i) begin
            for (int i = 0; i < DATA_WIDTH; i++) begin
                if (be_i[i/8]) begin
                    mem_q[addr_i][i] <= wdata_i[i];
                end
            end
        end
    end

    // Read data holds until the next read
    always_ff @(posedge clk_i) begin
        if (cs_i && !we_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule

`default_nettype wire

// File: hw/dir/dir_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dir_ctrl (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    output logic                       ready_o,
    output memctrl_pkg::way_vec_t      hit_way_o,
    output memctrl_pkg::way_vec_t      victim_way_o,
    input  wire logic                  match_i,
    input  wire memctrl_pkg::set_t     match_set_i,
    input  wire memctrl_pkg::tag_t     match_tag_i,
    input  wire logic                  update_lru_i,
    input  wire logic                  sel_victim_i,
    input  wire logic                  refill_i,
    input  wire memctrl_pkg::set_t     refill_set_i,
    input  wire memctrl_pkg::tag_t     refill_tag_i,
    plru_if.ctrl                       plru
);
    import memctrl_pkg::*;

    init_state_e               state_q;
    set_t                      init_set_q;
    dir_op_e                   dir_op;
    set_t                      dir_addr;
    way_vec_t                  dir_cs;
    way_vec_t                  dir_we;
    dir_entry_t                dir_wentry;
    dir_entry_t [NUM_WAYS-1:0] dir_rentry;
    set_t                      req_set_q;
    tag_t                      req_tag_q;
    logic                      match_q;

    // Clear one set per cycle after reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= INIT_CLEAR;
            init_set_q <= '0;
        end else if (state_q == INIT_CLEAR) begin
            init_set_q <= init_set_q + 1'b1;
            if (init_set_q == set_t'(NUM_SETS - 1)) begin
                state_q <= INIT_DONE;
            end
        end
    end

    assign ready_o = (state_q == INIT_DONE);

    // Access priority: init, lookup, victim read, refill write
    always_comb begin
        if (state_q == INIT_CLEAR) begin
            dir_op = DIR_INIT;
        end else if (match_i) begin
            dir_op = DIR_MATCH;
        end else if (sel_victim_i) begin
            dir_op = DIR_SEL_VICTIM;
        end else if (refill_i) begin
            dir_op = DIR_REFILL;
        end else begin
            dir_op = DIR_IDLE;
        end
    end

    always_comb begin
        dir_addr   = req_set_q;
        dir_cs     = '0;
        dir_we     = '0;
        dir_wentry = '0;
        case (dir_op)
            DIR_INIT: begin
                dir_addr = init_set_q;
                dir_cs   = '1;
                dir_we   = '1;
            end
            DIR_MATCH: begin
                dir_addr = match_set_i;
                dir_cs   = '1;
            end
            DIR_SEL_VICTIM: begin
                dir_addr = refill_set_i;
                dir_cs   = '1;
            end
            DIR_REFILL: begin
                dir_addr         = refill_set_i;
                dir_cs           = plru.victim_way;
                dir_we           = plru.victim_way;
                dir_wentry.valid = 1'b1;
                dir_wentry.tag   = refill_tag_i;
            end
            default: begin
                dir_cs = '0;
            end
        endcase
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_dir_ram
        sram_1rw #(
            .DATA_WIDTH (DIR_ENTRY_WIDTH),
            .DEPTH      (NUM_SETS)
        ) u_dir_ram (
            .clk_i   (clk_i),
            .cs_i    (dir_cs[w]),
            .we_i    (dir_we[w]),
            .be_i    ('1),
            .addr_i  (dir_addr),
            .wdata_i (dir_wentry),
            .rdata_o (dir_rentry[w])
        );

        assign hit_way_o[w] = match_q && dir_rentry[w].valid &&
                              (dir_rentry[w].tag == req_tag_q);
        assign plru.repl_valid[w] = dir_rentry[w].valid;
    end

    // Set and tag of the last read, compared one cycle later
    always_ff @(posedge clk_i) begin
        if (dir_op == DIR_MATCH || dir_op == DIR_SEL_VICTIM) begin
            req_set_q <= dir_addr;
        end
        if (dir_op == DIR_MATCH) begin
            req_tag_q <= match_tag_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            match_q <= 1'b0;
        end else begin
            match_q <= (dir_op == DIR_MATCH);
        end
    end

    assign plru.updt     = update_lru_i;
    assign plru.updt_set = req_set_q;
    assign plru.updt_way = hit_way_o;
    assign plru.repl     = refill_i;
    assign plru.repl_set = refill_i ? refill_set_i : req_set_q;

    assign victim_way_o = plru.victim_way;

endmodule

`default_nettype wire

// File: hw/dir/victim_mru.sv
`timescale 1ns/1ps
`default_nettype none

module victim_mru (
    input  wire logic clk_i,
    input  wire logic rst_ni,
    plru_if.sel       plru
);
    import memctrl_pkg::*;

    way_vec_t [NUM_SETS-1:0] mru_q;
    way_vec_t [NUM_SETS-1:0] mru_d;
    way_vec_t                cur_mru;
    way_vec_t                invalid_ways;

    // Mark a way as recently used, restart the set once every bit would be set
    function automatic way_vec_t mru_next(way_vec_t cur, way_vec_t way);
        way_vec_t nxt;
        nxt = cur | way;
        if (&nxt) begin
            nxt = way;
        end
        return nxt;
    endfunction

    // Lowest set bit of a vector, zero if none
    function automatic way_vec_t lowest_way(way_vec_t v);
        way_vec_t ret;
        ret = '0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (v[i]) begin
                ret = way_vec_t'(1) << i;
            end
        end
        return ret;
    endfunction

    assign cur_mru      = mru_q[plru.repl_set];
    assign invalid_ways = ~plru.repl_valid;

    // Invalid ways go first, otherwise the lowest way not recently used
    assign plru.victim_way = (|invalid_ways) ? lowest_way(invalid_ways)
                                             : lowest_way(~cur_mru);

    always_comb begin
        for (int s = 0; s < NUM_SETS; s++) begin
            mru_d[s] = mru_q[s];
            if (plru.updt && plru.updt_set == set_t'(s)) begin
                mru_d[s] = mru_next(mru_d[s], plru.updt_way);
            end
            if (plru.repl && plru.repl_set == set_t'(s)) begin
                mru_d[s] = mru_next(mru_d[s], plru.victim_way);
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mru_q <= '0;
        end else begin
            mru_q <= mru_d;
        end
    end

endmodule

`default_nettype wire

// File: hw/data/data_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module data_ctrl (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire memctrl_pkg::way_vec_t hit_way_i,
    input  wire logic                  read_i,
    input  wire memctrl_pkg::set_t     read_set_i,
    input  wire memctrl_pkg::word_idx_t read_word_i,
    output memctrl_pkg::data_word_t    read_data_o,
    input  wire logic                  write_i,
    input  wire memctrl_pkg::set_t     write_set_i,
    input  wire memctrl_pkg::word_idx_t write_word_i,
    input  wire memctrl_pkg::data_word_t write_data_i,
    input  wire memctrl_pkg::be_t      write_be_i,
    input  wire logic                  refill_i,
    input  wire memctrl_pkg::way_vec_t refill_way_i,
    input  wire memctrl_pkg::set_t     refill_set_i,
    input  wire memctrl_pkg::word_idx_t refill_word_i,
    input  wire memctrl_pkg::data_word_t refill_data_i
);
    import memctrl_pkg::*;

    logic                       wr_en;
    way_vec_t                   wr_way;
    logic [DATA_ADDR_WIDTH-1:0] wr_addr;
    data_word_t                 wr_data;
    be_t                        wr_be;
    logic [DATA_ADDR_WIDTH-1:0] ram_addr;
    way_vec_t                   ram_cs;
    way_vec_t                   ram_we;
    data_word_t [NUM_WAYS-1:0]  ram_rdata;
    logic                       read_q;

    // Refill wins over a request write
    always_comb begin
        wr_en   = 1'b0;
        wr_way  = '0;
        wr_addr = '0;
        wr_data = '0;
        wr_be   = '0;
        if (refill_i) begin
            wr_en   = 1'b1;
            wr_way  = refill_way_i;
            wr_addr = {refill_set_i, refill_word_i};
            wr_data = refill_data_i;
            wr_be   = '1;
        end else if (write_i) begin
            // A miss leaves the way vector empty and nothing is written
            wr_en   = 1'b1;
            wr_way  = hit_way_i;
            wr_addr = {write_set_i, write_word_i};
            wr_data = write_data_i;
            wr_be   = write_be_i;
        end
    end

    assign ram_addr = wr_en ? wr_addr : {read_set_i, read_word_i};
    assign ram_we   = wr_en ? wr_way : '0;
    assign ram_cs   = wr_en ? wr_way : {NUM_WAYS{read_i}};

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_data_ram
        sram_1rw #(
            .DATA_WIDTH (WORD_WIDTH),
            .DEPTH      (DATA_DEPTH)
        ) u_data_ram (
            .clk_i   (clk_i),
            .cs_i    (ram_cs[w]),
            .we_i    (ram_we[w]),
            .be_i    (wr_be),
            .addr_i  (ram_addr),
            .wdata_i (wr_data),
            .rdata_o (ram_rdata[w])
        );
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            read_q <= 1'b0;
        end else begin
            read_q <= read_i && !wr_en;
        end
    end

    // One-hot way mux, zero on a miss
    always_comb begin
        read_data_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (read_q && hit_way_i[w]) begin
                read_data_o = read_data_o | ram_rdata[w];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/memctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module memctrl_top (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    output logic                         ready_o,
    input  wire logic                    dir_match_i,
    input  wire memctrl_pkg::set_t       dir_match_set_i,
    input  wire memctrl_pkg::tag_t       dir_match_tag_i,
    input  wire logic                    dir_update_lru_i,
    output memctrl_pkg::way_vec_t        dir_hit_way_o,
    input  wire logic                    dir_sel_victim_i,
    input  wire logic                    dir_refill_i,
    input  wire memctrl_pkg::set_t       dir_refill_set_i,
    input  wire memctrl_pkg::tag_t       dir_refill_tag_i,
    output memctrl_pkg::way_vec_t        dir_victim_way_o,
    input  wire logic                    data_read_i,
    input  wire memctrl_pkg::set_t       data_read_set_i,
    input  wire memctrl_pkg::word_idx_t  data_read_word_i,
    output memctrl_pkg::data_word_t      data_read_data_o,
    input  wire logic                    data_write_i,
    input  wire memctrl_pkg::set_t       data_write_set_i,
    input  wire memctrl_pkg::word_idx_t  data_write_word_i,
    input  wire memctrl_pkg::data_word_t data_write_data_i,
    input  wire memctrl_pkg::be_t        data_write_be_i,
    input  wire logic                    data_refill_i,
    input  wire memctrl_pkg::way_vec_t   data_refill_way_i,
    input  wire memctrl_pkg::set_t       data_refill_set_i,
    input  wire memctrl_pkg::word_idx_t  data_refill_word_i,
    input  wire memctrl_pkg::data_word_t data_refill_data_i
);

    plru_if plru ();

    dir_ctrl u_dir_ctrl (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .ready_o      (ready_o),
        .hit_way_o    (dir_hit_way_o),
        .victim_way_o (dir_victim_way_o),
        .match_i      (dir_match_i),
        .match_set_i  (dir_match_set_i),
        .match_tag_i  (dir_match_tag_i),
        .update_lru_i (dir_update_lru_i),
        .sel_victim_i (dir_sel_victim_i),
        .refill_i     (dir_refill_i),
        .refill_set_i (dir_refill_set_i),
        .refill_tag_i (dir_refill_tag_i),
        .plru         (plru.ctrl)
    );

    victim_mru u_victim_mru (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .plru   (plru.sel)
    );

    // Hit way of the lookup steers both data reads and request writes
    data_ctrl u_data_ctrl (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .hit_way_i     (dir_hit_way_o),
        .read_i        (data_read_i),
        .read_set_i    (data_read_set_i),
        .read_word_i   (data_read_word_i),
        .read_data_o   (data_read_data_o),
        .write_i       (data_write_i),
        .write_set_i   (data_write_set_i),
        .write_word_i  (data_write_word_i),
        .write_data_i  (data_write_data_i),
        .write_be_i    (data_write_be_i),
        .refill_i      (data_refill_i),
        .refill_way_i  (data_refill_way_i),
        .refill_set_i  (data_refill_set_i),
        .refill_word_i (data_refill_word_i),
        .refill_data_i (data_refill_data_i)
    );

endmodule

`default_nettype wire

// File: dv/memctrl_assert.sv
`timescale 1ns/1ps
`default_nettype none

module memctrl_assert (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    input  wire logic                  ready_o,
    input  wire logic                  dir_match_i,
    input  wire logic                  dir_sel_victim_i,
    input  wire logic                  dir_refill_i,
    input  wire logic                  data_read_i,
    input  wire logic                  data_write_i,
    input  wire logic                  data_refill_i,
    input  wire memctrl_pkg::way_vec_t dir_hit_way_o
);

    // Failures so far, polled from the testbench
    int fail_count = 0;

    dir_strobe_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({dir_match_i, dir_sel_victim_i, dir_refill_i}))
        else begin
            $error("More than one directory strobe active");
            fail_count++;
        end

    data_strobe_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({data_read_i, data_write_i, data_refill_i}))
        else begin
            $error("More than one data strobe active");
            fail_count++;
        end

    hit_way_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(dir_hit_way_o))
        else begin
            $error("Hit way is not one-hot");
            fail_count++;
        end

    // Init runs once, so ready stays up
    ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ready_o |=> ready_o)
        else begin
            $error("ready_o fell after it had risen");
            fail_count++;
        end

endmodule

bind memctrl_top memctrl_assert u_memctrl_assert (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ready_o          (ready_o),
    .dir_match_i      (dir_match_i),
    .dir_sel_victim_i (dir_sel_victim_i),
    .dir_refill_i     (dir_refill_i),
    .data_read_i      (data_read_i),
    .data_write_i     (data_write_i),
    .data_refill_i    (data_refill_i),
    .dir_hit_way_o    (dir_hit_way_o)
);

`default_nettype wire

// File: dv/tb_memctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memctrl;
    import memctrl_pkg::*;

    localparam int unsigned RESET_CYCLES = 5;
    localparam int unsigned FIELD_COUNT  = 7;

    // One line of the stimulus file
    typedef struct packed {
        logic [7:0] op;
        set_t       set_idx;
        tag_t       tag;
        word_idx_t  word;
        data_word_t data;
        logic [3:0] aux;
        data_word_t exp;
    } cmd_t;

    logic       clk_i             = 1'b0;
    logic       rst_ni            = 1'b0;
    logic       ready_o;
    logic       dir_match_i       = 1'b0;
    set_t       dir_match_set_i   = '0;
    tag_t       dir_match_tag_i   = '0;
    logic       dir_update_lru_i  = 1'b0;
    way_vec_t   dir_hit_way_o;
    logic       dir_sel_victim_i  = 1'b0;
    logic       dir_refill_i      = 1'b0;
    set_t       dir_refill_set_i  = '0;
    tag_t       dir_refill_tag_i  = '0;
    way_vec_t   dir_victim_way_o;
    logic       data_read_i       = 1'b0;
    set_t       data_read_set_i   = '0;
    word_idx_t  data_read_word_i  = '0;
    data_word_t data_read_data_o;
    logic       data_write_i      = 1'b0;
    set_t       data_write_set_i  = '0;
    word_idx_t  data_write_word_i = '0;
    data_word_t data_write_data_i = '0;
    be_t        data_write_be_i   = '0;
    logic       data_refill_i     = 1'b0;
    way_vec_t   data_refill_way_i = '0;
    set_t       data_refill_set_i = '0;
    word_idx_t  data_refill_word_i = '0;
    data_word_t data_refill_data_i = '0;

    cmd_t cmds[$];
    logic loaded = 1'b0;

    memctrl_top UUT (.*);

    always #2 clk_i = ~clk_i;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, actual, expected));
        end
    endtask

    task automatic load_commands();
        int          fd;
        int          code;
        string       line;
        byte         op;
        logic [31:0] f_set;
        logic [31:0] f_tag;
        logic [31:0] f_word;
        logic [31:0] f_data;
        logic [31:0] f_aux;
        logic [31:0] f_exp;
        cmd_t        cmd;
        fd = $fopen("dv/memctrl_input.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open the stimulus file dv/memctrl_input.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            // Skip blank lines and the column description
            if (code > 1 && line[0] != "#") begin
                code = $sscanf(line, "%c %h %h %h %h %h %h", op, f_set, f_tag, f_word,
                               f_data, f_aux, f_exp);
                if (code != FIELD_COUNT) begin
                    abort_run($sformatf("Malformed line in the stimulus file: %s", line));
                end
                cmd.op      = op;
                cmd.set_idx = set_t'(f_set);
                cmd.tag     = tag_t'(f_tag);
                cmd.word    = word_idx_t'(f_word);
                cmd.data    = f_data;
                cmd.aux     = f_aux[3:0];
                cmd.exp     = f_exp;
                cmds.push_back(cmd);
            end
        end
        $fclose(fd);
    endtask

    // Cycles from reset release until ready_o rises
    task automatic wait_ready(input data_word_t exp);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (!ready_o) begin
            @(negedge clk_i);
            cycles++;
        end
        check_value("ready_o delay", cycles, exp);
    endtask

    task automatic lookup_check(input cmd_t cmd);
        @(posedge clk_i);
        dir_match_i     <= 1'b1;
        dir_match_set_i <= cmd.set_idx;
        dir_match_tag_i <= cmd.tag;
        @(posedge clk_i);
        dir_match_i      <= 1'b0;
        dir_update_lru_i <= cmd.aux[0];
        @(negedge clk_i);
        check_value("dir_hit_way_o", dir_hit_way_o, cmd.exp);
        @(posedge clk_i);
        dir_update_lru_i <= 1'b0;
    endtask

    // Victim read in one cycle, tag write into that way in the next
    task automatic victim_refill(input cmd_t cmd);
        @(posedge clk_i);
        dir_sel_victim_i <= 1'b1;
        dir_refill_set_i <= cmd.set_idx;
        @(posedge clk_i);
        dir_sel_victim_i <= 1'b0;
        dir_refill_i     <= 1'b1;
        dir_refill_tag_i <= cmd.tag;
        @(negedge clk_i);
        check_value("dir_victim_way_o", dir_victim_way_o, cmd.exp);
        @(posedge clk_i);
        dir_refill_i <= 1'b0;
    endtask

    task automatic refill_word(input cmd_t cmd);
        @(posedge clk_i);
        data_refill_i      <= 1'b1;
        data_refill_way_i  <= way_vec_t'(cmd.aux);
        data_refill_set_i  <= cmd.set_idx;
        data_refill_word_i <= cmd.word;
        data_refill_data_i <= cmd.data;
        @(posedge clk_i);
        data_refill_i <= 1'b0;
    endtask

    task automatic read_word(input cmd_t cmd);
        @(posedge clk_i);
        dir_match_i      <= 1'b1;
        dir_match_set_i  <= cmd.set_idx;
        dir_match_tag_i  <= cmd.tag;
        data_read_i      <= 1'b1;
        data_read_set_i  <= cmd.set_idx;
        data_read_word_i <= cmd.word;
        @(posedge clk_i);
        dir_match_i <= 1'b0;
        data_read_i <= 1'b0;
        @(negedge clk_i);
        check_value("data_read_data_o", data_read_data_o, cmd.exp);
    endtask

    // Lookup first, the write follows on the returned hit way
    task automatic write_word(input cmd_t cmd);
        @(posedge clk_i);
        dir_match_i     <= 1'b1;
        dir_match_set_i <= cmd.set_idx;
        dir_match_tag_i <= cmd.tag;
        @(posedge clk_i);
        dir_match_i       <= 1'b0;
        data_write_i      <= 1'b1;
        data_write_set_i  <= cmd.set_idx;
        data_write_word_i <= cmd.word;
        data_write_data_i <= cmd.data;
        data_write_be_i   <= be_t'(cmd.aux);
        @(negedge clk_i);
        check_value("dir_hit_way_o", dir_hit_way_o, cmd.exp);
        @(posedge clk_i);
        data_write_i <= 1'b0;
    endtask

    initial begin : main
        cmd_t cmd;
        load_commands();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        foreach (cmds[i]) begin
            cmd = cmds[i];
            case (cmd.op)
                "R": wait_ready(cmd.exp);
                "L": lookup_check(cmd);
                "V": victim_refill(cmd);
                "F": refill_word(cmd);
                "D": read_word(cmd);
                "W": write_word(cmd);
                default: abort_run($sformatf("Unknown command %c in the stimulus file", cmd.op));
            endcase
        end
        repeat (2) @(posedge clk_i);
        if (UUT.u_memctrl_assert.fail_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            abort_run("A bound assertion reported an error");
        end
    end

    initial begin : assert_watch
        wait (UUT.u_memctrl_assert.fail_count != 0);
        abort_run("A bound assertion reported an error");
    end

    // Budget covers init, reset and a few cycles per command
    initial begin : watchdog
        wait (loaded);
        repeat (NUM_SETS + 20 + 4 * cmds.size()) @(posedge clk_i);
        abort_run("Timeout: the command list did not finish in time");
    end

endmodule

`default_nettype wire

// File: dv/memctrl_input.txt
# columns: op set tag word data aux exp, all hex; ops R ready, L lookup, V victim+refill,
# F data refill, D lookup+read, W lookup+write; aux = lru update, refill way or byte enables
R 0 00 0 00000000 0 10
L 0 00 0 00000000 0 0
L f ff 0 00000000 1 0
V 3 a1 0 00000000 0 1
V 3 a2 0 00000000 0 2
V 3 a3 0 00000000 0 4
V 3 a4 0 00000000 0 8
L 3 a1 0 00000000 0 1
L 3 a2 0 00000000 0 2
L 3 a3 0 00000000 0 4
L 3 a4 0 00000000 0 8
L 3 a5 0 00000000 0 0
L 3 a1 0 00000000 1 1
L 3 a2 0 00000000 1 2
V 3 b0 0 00000000 0 4
V 3 b1 0 00000000 0 1
L 3 b1 0 00000000 0 1
L 3 a1 0 00000000 0 0
L 3 b0 0 00000000 0 4
L 3 a2 0 00000000 1 2
L 3 a4 0 00000000 1 8
V 3 b2 0 00000000 0 1
L 3 b2 0 00000000 0 1
V 7 c0 0 00000000 0 1
V 7 c1 0 00000000 0 2
F 7 00 0 11110000 1 0
F 7 00 2 11110002 1 0
F 7 00 3 11110003 1 0
F 7 00 1 22220001 2 0
D 7 c0 0 00000000 0 11110000
D 7 c1 1 00000000 0 22220001
D 7 c9 0 00000000 0 0
W 7 c0 2 aabbccdd 5 1
W 7 cf 2 ffffffff f 0
D 7 c0 2 00000000 0 11bb00dd
W 7 c1 1 99887766 8 2
D 7 c1 1 00000000 0 99220001

// File: vlog.f
common/memctrl_pkg.sv
common/plru_if.sv
hw/sram_1rw.sv
hw/dir/dir_ctrl.sv
hw/dir/victim_mru.sv
hw/data/data_ctrl.sv
hw/memctrl_top.sv
dv/memctrl_assert.sv
dv/tb_memctrl.sv

// File: Bender.yml
package:
  name: memctrl

sources:
  - files:
      - common/memctrl_pkg.sv
      - common/plru_if.sv
      - hw/sram_1rw.sv
      - hw/dir/dir_ctrl.sv
      - hw/dir/victim_mru.sv
      - hw/data/data_ctrl.sv
      - hw/memctrl_top.sv
  - target: test
    files:
      - dv/memctrl_assert.sv
      - dv/tb_memctrl.sv
